/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_cart
FILELIST  = sim.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = TESTS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run and check $(LOG)"
	@echo "  clean  remove build output and log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* common/cart_pkg.sv */
// shared definitions for the cartridge side
// header word locations, MBC1 constants, store address layout
// packed structs for cpu bus, download words, header and store requests

`default_nettype none

package cart_pkg;

	// --------------------
	// header locations
	// --------------------

	// store is 16 bit wide so byte $147 sits in word $a3 (low byte)
	localparam logic [23:0] HDR_TYPE_WORD = 24'h0000a3;
	// $148 rom size in the high byte, $149 ram size in the low byte
	localparam logic [23:0] HDR_SIZE_WORD = 24'h0000a4;

	// --------------------
	// MBC1 constants
	// --------------------

	// low nibble written to 0x0000-0x1fff that opens cart ram
	localparam logic [3:0] RAM_ENABLE_KEY = 4'ha;
	// mbc1, mbc1+ram, mbc1+ram+battery
	localparam logic [7:0] MBC1_TYPE_MIN = 8'd1;
	localparam logic [7:0] MBC1_TYPE_MAX = 8'd3;

	// bank field bit that moves an access into the ram half of the store
	localparam int RAM_BANK_BIT = 8;
	// word bits inside one 8k bank
	localparam int BANK_WORD_W = 12;

	// --------------------
	// bundles
	// --------------------

	// one cpu access on the cartridge bus
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  wdata;
		logic        rd;
		logic        wr;
	} cart_bus_t;

	// one word from the rom loader
	typedef struct packed {
		logic [23:0] addr;
		logic [15:0] data;
		logic        wr;
	} dl_write_t;

	// header fields captured while loading
	typedef struct packed {
		logic [7:0] mbc_type;
		logic [7:0] rom_size;
		logic [7:0] ram_size;
	} hdr_t;

	// store request, be[1] is the high (even) byte
	typedef struct packed {
		logic [23:0] addr;
		logic [15:0] data;
		logic [1:0]  be;
		logic        we;
		logic        oe;
	} mem_req_t;

endpackage

`default_nettype wire

/* design/cart_store.sv */
// on-chip cartridge word store
// byte strobe writes, one cycle registered read

`default_nettype none

module cart_store #(
	parameter int ADDR_W = 17
) (
	input  logic               clk4,
	input  cart_pkg::mem_req_t mem_req,
	output logic [15:0]        rd_word
);
	import cart_pkg::*;

	// bottom half rom, top half ram, as in the store map
	logic [15:0]       mem [0:(1 << ADDR_W) - 1];
	logic [ADDR_W-1:0] idx;

	// ram region bit on top, low word bits below
	assign idx = {mem_req.addr[BANK_WORD_W + RAM_BANK_BIT], mem_req.addr[ADDR_W-2:0]};

	always_ff @(posedge clk4) begin
		if (mem_req.we) begin
			if (mem_req.be[1]) begin
				mem[idx][15:8] <= mem_req.data[15:8];
			end
			if (mem_req.be[0]) begin
				mem[idx][7:0] <= mem_req.data[7:0];
			end
		end
		// word only refreshed on reads
		if (mem_req.oe) begin
			rd_word <= mem[idx];
		end
	end

endmodule

`default_nettype wire

/* design/cart_top.sv */
// cartridge side top level
// header capture, MBC1 registers, bank mapping, store arbiter, word store

`default_nettype none

module cart_top (
	input  logic                clk4,
	input  logic                reset,
	input  logic                force_mbc1,
	input  logic                dl_active,
	input  cart_pkg::dl_write_t dl,
	input  cart_pkg::cart_bus_t cart,
	output logic [7:0]          cart_do
);
	import cart_pkg::*;

	hdr_t        hdr;
	logic [4:0]  rom_bank_reg;
	logic [1:0]  ram_bank_reg;
	logic        mode;
	logic        ram_enable;
	mem_req_t    cart_req;
	mem_req_t    mem_req;
	logic [15:0] rd_word;

	// --------------------
	// mapper
	// --------------------

	header_capture header_capture_i (
		.clk4      (clk4),
		.reset     (reset),
		.dl_active (dl_active),
		.dl        (dl),
		.hdr       (hdr)
	);

	mbc1_regs mbc1_regs_i (
		.clk4         (clk4),
		.reset        (reset),
		.cart         (cart),
		.rom_bank_reg (rom_bank_reg),
		.ram_bank_reg (ram_bank_reg),
		.mode         (mode),
		.ram_enable   (ram_enable)
	);

	bank_map bank_map_i (
		.cart         (cart),
		.hdr          (hdr),
		.force_mbc1   (force_mbc1),
		.rom_bank_reg (rom_bank_reg),
		.ram_bank_reg (ram_bank_reg),
		.mode         (mode),
		.ram_enable   (ram_enable),
		.cart_req     (cart_req)
	);

	// --------------------
	// store side
	// --------------------

	mem_arbiter mem_arbiter_i (
		.clk4      (clk4),
		.reset     (reset),
		.dl_active (dl_active),
		.dl        (dl),
		.cart_req  (cart_req),
		.mem_req   (mem_req),
		.rd_word   (rd_word),
		.cart_do   (cart_do)
	);

	cart_store cart_store_i (
		.clk4    (clk4),
		.mem_req (mem_req),
		.rd_word (rd_word)
	);

endmodule

`default_nettype wire

/* design/mem_arbiter.sv */
// store arbiter between rom download and cartridge path
// download wins while active, cart read byte is picked one cycle later

`default_nettype none

module mem_arbiter (
	input  logic                clk4,
	input  logic                reset,
	input  logic                dl_active,
	input  cart_pkg::dl_write_t dl,
	input  cart_pkg::mem_req_t  cart_req,
	output cart_pkg::mem_req_t  mem_req,
	input  logic [15:0]         rd_word,
	output logic [7:0]          cart_do
);

	// low byte select of the read in flight
	logic odd_sel;

	// --------------------
	// request mux
	// --------------------

	always_comb begin
		if (dl_active) begin
			// loader always writes whole words, cart accesses are dropped
			mem_req.addr = dl.addr;
			mem_req.data = dl.data;
			mem_req.be   = 2'b11;
			mem_req.we   = dl.wr;
			mem_req.oe   = 1'b0;
		end else begin
			mem_req = cart_req;
		end
	end

	// --------------------
	// read byte select
	// --------------------

	// store word lands next cycle, so the select follows it
	always_ff @(posedge clk4) begin
		if (reset) begin
			odd_sel <= 1'b0;
		end else if (!dl_active && cart_req.oe) begin
			odd_sel <= cart_req.be[0];
		end
	end

	// rd_word and odd_sel only move on cart reads, so cart_do holds in download
	assign cart_do = odd_sel ? rd_word[7:0] : rd_word[15:8];

	// store port has no read-during-write case
	we_oe_excl_a: assert property (
		@(posedge clk4) disable iff (reset)
		!(mem_req.we && mem_req.oe)
	);

endmodule

`default_nettype wire

/* mapper/bank_map.sv */
// cpu address to store word address mapping
// rom/ram size masks, mapper select, bank field, ram write gating

`default_nettype none

module bank_map (
	input  cart_pkg::cart_bus_t cart,
	input  cart_pkg::hdr_t      hdr,
	input  logic                force_mbc1,
	input  logic [4:0]          rom_bank_reg,
	input  logic [1:0]          ram_bank_reg,
	input  logic                mode,
	input  logic                ram_enable,
	output cart_pkg::mem_req_t  cart_req
);
	import cart_pkg::*;

	logic       mbc1;
	logic [6:0] rom_mask;
	logic [1:0] ram_mask;
	logic [6:0] rom_bank;
	logic [1:0] ram_bank;
	logic       ram_region;
	logic [8:0] bank;

	// mapper select
	assign mbc1 = force_mbc1 ||
		(hdr.mbc_type >= MBC1_TYPE_MIN && hdr.mbc_type <= MBC1_TYPE_MAX);

	// --------------------
	// size masks
	// --------------------

	// banks above the rom size wrap around, so small roms mirror
	always_comb begin
		case (hdr.rom_size)
			8'h01:   rom_mask = 7'h03;
			8'h02:   rom_mask = 7'h07;
			8'h03:   rom_mask = 7'h0f;
			8'h04:   rom_mask = 7'h1f;
			8'h05:   rom_mask = 7'h3f;
			8'h06:   rom_mask = 7'h7f;
			// 72 and 80 bank parts
			8'h52:   rom_mask = 7'h47;
			8'h53:   rom_mask = 7'h4f;
			// 96 banks, also code 0 (unused by 32k linear carts)
			default: rom_mask = 7'h5f;
		endcase
	end

	// 32k ram gets four banks, smaller sizes only one
	assign ram_mask = (hdr.ram_size >= 8'd3) ? 2'b11 : 2'b00;

	// --------------------
	// bank field
	// --------------------

	// mode 0: ram bank reg supplies rom bits 6:5
	assign rom_bank = {mode ? 2'b00 : ram_bank_reg, rom_bank_reg} & rom_mask;
	// mode 1: ram bank reg banks the ram
	assign ram_bank = (mode ? ram_bank_reg : 2'b00) & ram_mask;
	assign ram_region = (cart.addr[15:13] == 3'b101);

	always_comb begin
		bank = '0;
		if (!mbc1) begin
			// plain 32k cart
			bank[1:0] = cart.addr[14:13];
		end else if (cart.addr[15:14] == 2'b00) begin
			bank[0] = cart.addr[13];
		end else if (cart.addr[15:14] == 2'b01) begin
			bank = {1'b0, rom_bank, cart.addr[13]};
		end else if (ram_region) begin
			bank[RAM_BANK_BIT] = 1'b1;
			bank[1:0]          = ram_bank;
		end
	end

	// even byte in the high half of the word
	always_comb begin
		cart_req.addr = {3'b000, bank, cart.addr[BANK_WORD_W:1]};
		cart_req.data = {cart.wdata, cart.wdata};
		cart_req.be   = {~cart.addr[0], cart.addr[0]};
		cart_req.we   = cart.wr && mbc1 && ram_enable && ram_region;
		cart_req.oe   = cart.rd;
	end

endmodule

`default_nettype wire

/* mapper/header_capture.sv */
// header field capture during rom download
// latches mapper type, rom size and ram size codes

`default_nettype none

module header_capture (
	input  logic                clk4,
	input  logic                reset,
	input  logic                dl_active,
	input  cart_pkg::dl_write_t dl,
	output cart_pkg::hdr_t      hdr
);
	import cart_pkg::*;

	// only loader writes inside a download count
	logic dl_wr;

	assign dl_wr = dl_active && dl.wr;

	always_ff @(posedge clk4) begin
		if (reset) begin
			hdr <= '0;
		end else if (dl_wr) begin
			// type byte $147 is odd, so low half of its word
			if (dl.addr == HDR_TYPE_WORD) begin
				hdr.mbc_type <= dl.data[7:0];
			end
			// $148 even -> high half, $149 odd -> low half
			if (dl.addr == HDR_SIZE_WORD) begin
				hdr.rom_size <= dl.data[15:8];
				hdr.ram_size <= dl.data[7:0];
			end
		end
	end

	// mapper setup stays frozen between downloads
	hdr_frozen_a: assert property (
		@(posedge clk4) disable iff (reset)
		!dl_active |=> $stable(hdr)
	);

endmodule

`default_nettype wire

/* mapper/mbc1_regs.sv */
// MBC1 control registers
// ram enable, rom bank, ram bank and banking mode
// written by the cpu through the 0x0000-0x7fff control window

`default_nettype none

module mbc1_regs (
	input  logic                clk4,
	input  logic                reset,
	input  cart_pkg::cart_bus_t cart,
	output logic [4:0]          rom_bank_reg,
	output logic [1:0]          ram_bank_reg,
	output logic                mode,
	output logic                ram_enable
);
	import cart_pkg::*;

	// 8k region of the write, only the low four matter
	logic [2:0] region;

	assign region = cart.addr[15:13];

	always_ff @(posedge clk4) begin
		if (reset) begin
			rom_bank_reg <= 5'd1;
			ram_bank_reg <= 2'd0;
			ram_enable   <= 1'b0;
			mode         <= 1'b0;
		end else if (cart.wr) begin
			case (region)
				// any value other than the key closes the ram
				3'b000: ram_enable <= (cart.wdata[3:0] == RAM_ENABLE_KEY);
				// bank 0 can not be selected here, hardware turns it into 1
				3'b001: begin
					if (cart.wdata[4:0] == 5'd0) begin
						rom_bank_reg <= 5'd1;
					end else begin
						rom_bank_reg <= cart.wdata[4:0];
					end
				end
				// ram bank or upper rom bits, depending on mode
				3'b010: ram_bank_reg <= cart.wdata[1:0];
				// 0 = 16/8 mode, 1 = 4/32 mode
				3'b011: mode <= cart.wdata[0];
				// writes elsewhere go to rom or cart ram
				default: ;
			endcase
		end
	end

	// switchable window must never show bank 0
	rom_bank_nonzero_a: assert property (
		@(posedge clk4) disable iff (reset)
		rom_bank_reg != 5'd0
	);

endmodule

`default_nettype wire

/* sim.f */
+incdir+test
common/cart_pkg.sv
mapper/header_capture.sv
mapper/mbc1_regs.sv
mapper/bank_map.sv
design/mem_arbiter.sv
design/cart_store.sv
design/cart_top.sv
test/tb_cart.sv

/* test/tb_cart_model.svh */
// reference model for the cartridge testbench
// model state, rom image bytes, size masks, expected read byte

`ifndef TB_CART_MODEL_SVH
`define TB_CART_MODEL_SVH

// --------------------
// model state
// --------------------

// header of the last download
logic [7:0] m_type;
logic [7:0] m_rom;
logic [7:0] m_ram;
logic       m_force;
// MBC1 registers as the cpu wrote them
logic [4:0] m_rom_bank;
logic [1:0] m_ram_bank;
logic       m_mode;
logic       m_ram_en;
// cart ram, four 8k banks
logic [7:0] ram_model [0:32767];

function automatic void model_reset();
	m_type     = 8'h00;
	m_rom      = 8'h00;
	m_ram      = 8'h00;
	m_rom_bank = 5'd1;
	m_ram_bank = 2'd0;
	m_mode     = 1'b0;
	m_ram_en   = 1'b0;
endfunction

// byte of the rom image, header bytes come from the test
function automatic logic [7:0] image_byte(input logic [23:0] a);
	logic [7:0] b;
	case (a)
		24'h000147: b = m_type;
		24'h000148: b = m_rom;
		24'h000149: b = m_ram;
		default:    b = a[7:0] ^ a[15:8] ^ 8'h5a;
	endcase
	return b;
endfunction

function automatic logic is_mbc1();
	return m_force || (m_type >= 8'd1 && m_type <= 8'd3);
endfunction

// banks above the rom size wrap
function automatic logic [6:0] rom_mask_of(input logic [7:0] code);
	case (code)
		8'h01:   return 7'd3;
		8'h02:   return 7'd7;
		8'h03:   return 7'd15;
		8'h04:   return 7'd31;
		8'h05:   return 7'd63;
		8'h06:   return 7'd127;
		8'h52:   return 7'h47;
		8'h53:   return 7'h4f;
		default: return 7'h5f;
	endcase
endfunction

function automatic logic [1:0] ram_mask_of(input logic [7:0] code);
	return (code >= 8'd3) ? 2'b11 : 2'b00;
endfunction

// byte a cpu read of addr should return
function automatic logic [7:0] expected_byte(input logic [15:0] addr);
	logic [6:0] bank;
	logic [1:0] rbank;
	bank  = {m_mode ? 2'b00 : m_ram_bank, m_rom_bank} & rom_mask_of(m_rom);
	rbank = (m_mode ? m_ram_bank : 2'b00) & ram_mask_of(m_ram);
	// fixed bank, or whole 32k of a plain cart
	if (!addr[15] && (!addr[14] || !is_mbc1())) begin
		return image_byte({8'd0, addr});
	end
	if (!addr[15]) begin
		return image_byte({3'b000, bank, addr[13:0]});
	end
	return ram_model[{rbank, addr[12:0]}];
endfunction

// cpu write as the mapper should see it, dropped during download
function automatic void model_write(input logic [15:0] addr, input logic [7:0] data,
		input logic dropped);
	logic [1:0] rbank;
	rbank = (m_mode ? m_ram_bank : 2'b00) & ram_mask_of(m_ram);
	case (addr[15:13])
		3'd0: m_ram_en = (data[3:0] == 4'ha);
		3'd1: m_rom_bank = (data[4:0] == 5'd0) ? 5'd1 : data[4:0];
		3'd2: m_ram_bank = data[1:0];
		3'd3: m_mode = data[0];
		3'd5: begin
			if (!dropped && m_ram_en && is_mbc1()) begin
				ram_model[{rbank, addr[12:0]}] = data;
			end
		end
		default: ;
	endcase
endfunction

`endif

/* test/tb_cart.sv */
// cartridge side testbench
// clock, reset, download and cpu bus tasks
// read checker against the reference model, closing report

`default_nettype none

module tb_cart;
	import cart_pkg::*;

	logic       clk4;
	logic       reset;
	logic       force_mbc1;
	logic       dl_active;
	dl_write_t  dl;
	cart_bus_t  cart;
	logic [7:0] cart_do;

	int          errors;
	int          checks;
	int          seed;
	// reads in flight, oldest first
	logic [7:0]  exp_q [$];
	string       name_q [$];
	logic        rd_seen;
	// ram locations the tests wrote
	logic [15:0] ram_addr_q [$];
	logic [1:0]  ram_bank_q [$];

	`include "tb_cart_model.svh"

	cart_top cart_top_i (
		.clk4       (clk4),
		.reset      (reset),
		.force_mbc1 (force_mbc1),
		.dl_active  (dl_active),
		.dl         (dl),
		.cart       (cart),
		.cart_do    (cart_do)
	);

	always #20 clk4 = ~clk4;

	// --------------------
	// read checker
	// --------------------

	// a read taken at this edge has its byte on cart_do right after it
	always @(posedge clk4) begin
		rd_seen <= cart.rd && !dl_active;
	end

	// half a cycle later cart_do is settled
	always @(negedge clk4) begin : compare
		logic [7:0] want;
		string      name;
		if (rd_seen) begin
			assert (exp_q.size() != 0) else begin
				errors++;
				$display("cart_do returned a byte with no read waiting for it");
			end
			if (exp_q.size() != 0) begin
				want = exp_q.pop_front();
				name = name_q.pop_front();
				checks++;
				assert (cart_do === want) else begin
					errors++;
					$display("ERR %s: expected %02h, actual %02h", name, want, cart_do);
				end
			end
		end
	end

	// --------------------
	// bus tasks
	// --------------------

	// strobes stay up until the next access or bus_idle
	task automatic bus_cycle(input logic [15:0] addr, input logic [7:0] data,
			input logic rd, input logic wr);
		@(posedge clk4);
		cart <= {addr, data, rd, wr};
	endtask

	task automatic bus_idle();
		@(posedge clk4);
		cart <= '0;
	endtask

	task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
		bus_cycle(addr, data, 1'b0, 1'b1);
		model_write(addr, data, dl_active);
	endtask

	task automatic cpu_read(input logic [15:0] addr, input string name);
		bus_cycle(addr, 8'h00, 1'b1, 1'b0);
		exp_q.push_back(expected_byte(addr));
		name_q.push_back(name);
	endtask

	task automatic wait_reads();
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < 50) begin
			@(posedge clk4);
			n++;
		end
		if (exp_q.size() != 0) begin
			errors++;
			$display("timeout: %0d reads never got a byte back", exp_q.size());
			exp_q.delete();
			name_q.delete();
		end
	endtask

	// full 128k image, even byte in the high half
	task automatic download(input logic [7:0] mtype, input logic [7:0] rom,
			input logic [7:0] ram);
		logic [16:0] w;
		m_type = mtype;
		m_rom  = rom;
		m_ram  = ram;
		@(posedge clk4);
		dl_active <= 1'b1;
		for (w = 17'd0; w < 17'h10000; w++) begin
			@(posedge clk4);
			dl <= {7'd0, w, image_byte({7'd0, w[15:0], 1'b0}),
				image_byte({7'd0, w[15:0], 1'b1}), 1'b1};
		end
		@(posedge clk4);
		dl        <= '0;
		dl_active <= 1'b0;
	endtask

	// --------------------
	// test steps
	// --------------------

	// banks 0..7 in order, then random ones
	task automatic bank_sweep(input string name);
		logic [31:0] r;
		for (int v = 0; v < 12; v++) begin
			r = $random(seed);
			cpu_write(16'h2000, (v < 8) ? 8'(v) : r[7:0]);
			cpu_read(16'h4000, name);
			cpu_read({2'b01, r[13:0]}, name);
			cpu_read(16'h7fff, name);
		end
		bus_idle();
		wait_reads();
	endtask

	// select each recorded bank and read its location back
	task automatic ram_reread(input string name);
		for (int i = 0; i < ram_addr_q.size(); i++) begin
			cpu_write(16'h4000, {6'd0, ram_bank_q[i]});
			cpu_read(ram_addr_q[i], name);
		end
		bus_idle();
		wait_reads();
	endtask

	task automatic ram_scribble();
		logic [31:0] r;
		for (int i = 0; i < ram_addr_q.size(); i++) begin
			r = $random(seed);
			cpu_write(16'h4000, {6'd0, ram_bank_q[i]});
			cpu_write(ram_addr_q[i], r[7:0]);
		end
	endtask

	task automatic test_ram();
		logic [31:0] r;
		logic [15:0] a;
		download(8'h03, 8'h02, 8'h03);
		cpu_write(16'h6000, 8'h01);
		cpu_write(16'h0000, 8'h0a);
		for (int k = 0; k < 4; k++) begin
			r = $random(seed);
			a = {3'b101, r[12:0]};
			// same offset in every bank, bank number in the low data bits
			for (int b = 0; b < 4; b++) begin
				cpu_write(16'h4000, 8'(b));
				cpu_write(a, {r[20:15], 2'(b)});
				ram_addr_q.push_back(a);
				ram_bank_q.push_back(2'(b));
			end
		end
		ram_reread("ram_bank");
		// fresh reset, ram stays closed until the key arrives
		@(posedge clk4);
		reset <= 1'b1;
		repeat (10) @(posedge clk4);
		reset <= 1'b0;
		model_reset();
		download(8'h03, 8'h02, 8'h03);
		cpu_write(16'h6000, 8'h01);
		ram_scribble();
		ram_reread("ram_reset");
		// closed ram, then a non-key value keeps it closed
		cpu_write(16'h0000, 8'h00);
		ram_scribble();
		cpu_write(16'h0000, 8'h0b);
		ram_scribble();
		cpu_write(16'h0000, 8'h0a);
		ram_reread("ram_gate");
	endtask

	task automatic test_isolation();
		@(posedge clk4);
		dl_active <= 1'b1;
		// mapper still on the last ram bank
		for (int i = 0; i < ram_addr_q.size(); i++) begin
			cpu_write(ram_addr_q[i], 8'hc3);
		end
		bus_idle();
		dl_active <= 1'b0;
		ram_reread("dl_isolation");
	endtask

	// --------------------
	// main sequence
	// --------------------

	initial begin
		errors     = 0;
		checks     = 0;
		seed       = 32'hbbc01cc0;
		clk4       = 1'b0;
		reset      = 1'b1;
		force_mbc1 = 1'b0;
		dl_active  = 1'b0;
		dl         = '0;
		cart       = '0;
		m_force    = 1'b0;
		model_reset();
		repeat (10) @(posedge clk4);
		reset <= 1'b0;

		// plain 32k cart
		download(8'h00, 8'h00, 8'h00);
		for (int a = 0; a < 32768; a += 59) begin
			cpu_read(16'(a), "linear");
		end
		cpu_read(16'h7fff, "linear");
		bus_idle();
		wait_reads();

		download(8'h01, 8'h02, 8'h00);
		bank_sweep("mbc1_bank");

		// 64k rom, bank 6 lands on bank 2
		download(8'h01, 8'h01, 8'h00);
		cpu_write(16'h2000, 8'h06);
		cpu_read(16'h4000, "mirror");
		cpu_read(16'h5a5a, "mirror");
		cpu_read(16'h7fff, "mirror");
		bank_sweep("mirror");

		force_mbc1 <= 1'b1;
		m_force = 1'b1;
		download(8'h00, 8'h02, 8'h00);
		bank_sweep("forced_mbc1");
		force_mbc1 <= 1'b0;
		m_force = 1'b0;

		test_ram();
		test_isolation();

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
